//--- Bender.yml
package:
  name: spi_sd_host

sources:
  # RTL, package first
  - include_dirs:
      - src
    files:
      - src/spi_pkg.sv
      - src/spi_byte_engine.sv
      - src/spi_word_sequencer.sv
      - src/spi_sd_host.sv
  # Testbench and bound assertions
  - target: test
    include_dirs:
      - src
    files:
      - test/spi_sd_host_assertions.sv
      - test/spi_sd_host_tb.sv

//--- all.f
+incdir+src
src/spi_pkg.sv
src/spi_byte_engine.sv
src/spi_word_sequencer.sv
src/spi_sd_host.sv
test/spi_sd_host_assertions.sv
test/spi_sd_host_tb.sv

//--- src/spi_byte_engine.sv
// Mode 0 only, MSB first, fixed divider; i_tx_start is ignored unless o_tx_ready is high
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_byte_engine (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [`SPI_BYTE_W-1:0] i_tx_byte,
  input  logic                   i_tx_start,
  output logic                   o_tx_ready,
  output logic [`SPI_BYTE_W-1:0] o_rx_byte,
  output logic                   o_rx_valid,
  output spi_pkg::spi_pins_t     o_pins,
  input  logic                   i_miso
);

  localparam int BYTE_W = `SPI_BYTE_W;
  localparam int HALF   = `SPI_CLK_HALF;
  // Counter widths, at least one bit each
  localparam int HC_W   = (HALF > 1) ? $clog2(HALF) : 1;
  localparam int BC_W   = (BYTE_W > 1) ? $clog2(BYTE_W) : 1;

  spi_pkg::engine_state_e state_q;
  spi_pkg::spi_pins_t     pins_q;

  logic [HC_W-1:0]   half_cnt_q;
  logic [BC_W-1:0]   bit_cnt_q;
  logic [BYTE_W-1:0] tx_shift_q;
  logic [BYTE_W-1:0] rx_shift_q;
  logic [BYTE_W-1:0] rx_byte_q;
  logic              rx_valid_q;
  logic              half_tick;
  logic              last_bit;

  // End of the current SCK half period
  assign half_tick = (half_cnt_q == HC_W'(HALF - 1));
  assign last_bit  = (bit_cnt_q == BC_W'(BYTE_W - 1));

  // Control state and pins
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q    <= spi_pkg::ST_IDLE;
      pins_q     <= '0;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      // Single cycle pulse
      rx_valid_q <= 1'b0;
      case (state_q)
        spi_pkg::ST_IDLE: begin
          half_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (i_tx_start) begin
            // First bit set up before the first rising edge
            pins_q.mosi <= i_tx_byte[BYTE_W-1];
            state_q     <= spi_pkg::ST_SHIFT;
          end
        end
        spi_pkg::ST_SHIFT: begin
          half_cnt_q <= half_cnt_q + 1'b1;
          if (half_tick) begin
            half_cnt_q <= '0;
            pins_q.sck <= ~pins_q.sck;
            if (!pins_q.sck) begin
              // Rising edge, last sample ends shifting
              if (last_bit) begin
                state_q <= spi_pkg::ST_LAST;
              end
            end else begin
              // Falling edge, next bit onto MOSI
              bit_cnt_q   <= bit_cnt_q + 1'b1;
              pins_q.mosi <= tx_shift_q[BYTE_W-2];
            end
          end
        end
        spi_pkg::ST_LAST: begin
          // Hold the final high phase, then SCK back low
          half_cnt_q <= half_cnt_q + 1'b1;
          if (half_tick) begin
            half_cnt_q  <= '0;
            pins_q.sck  <= 1'b0;
            pins_q.mosi <= 1'b0;
            rx_valid_q  <= 1'b1;
            state_q     <= spi_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= spi_pkg::ST_IDLE;
          pins_q  <= '0;
        end
      endcase
    end
  end

  // Shift registers and received byte
  always_ff @(posedge clk) begin
    if ((state_q == spi_pkg::ST_IDLE) && i_tx_start) begin
      tx_shift_q <= i_tx_byte;
    end else if ((state_q == spi_pkg::ST_SHIFT) && half_tick) begin
      if (!pins_q.sck) begin
        // MISO in on rising SCK
        rx_shift_q <= {rx_shift_q[BYTE_W-2:0], i_miso};
      end else begin
        tx_shift_q <= {tx_shift_q[BYTE_W-2:0], 1'b0};
      end
    end
    // Full byte captured on the way out of ST_LAST
    if ((state_q == spi_pkg::ST_LAST) && half_tick) begin
      rx_byte_q <= rx_shift_q;
    end
  end

  // Ready only when idle
  assign o_tx_ready = (state_q == spi_pkg::ST_IDLE);
  assign o_rx_byte  = rx_byte_q;
  assign o_rx_valid = rx_valid_q;
  assign o_pins     = pins_q;

endmodule

//--- src/spi_cfg.svh
// SCK divider and data widths are fixed at build time; SPI_CLK_HALF must be at least 1
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// clk cycles per SCK half period
// 2 gives SCK at clk/4
`define SPI_CLK_HALF 2

// Bits per SPI byte, shifted MSB first
`define SPI_BYTE_W 8

// Bytes per word transfer
// Lowest byte goes out first
`define SPI_WORD_BYTES 4

// Register port data width
`define SPI_WORD_W (`SPI_BYTE_W * `SPI_WORD_BYTES)

`endif

//--- src/spi_pkg.sv
// Shared types for the SD SPI host; field widths follow spi_cfg.svh
`include "spi_cfg.svh"

package spi_pkg;

  // Byte engine FSM
  // ST_LAST holds the final high SCK phase before rx_valid
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_SHIFT = 2'd1,
    ST_LAST  = 2'd2
  } engine_state_e;

  // Register strobe kind, latched by the sequencer
  typedef enum logic {
    XFER_BYTE = 1'b0,
    XFER_WORD = 1'b1
  } xfer_kind_e;

  // Register write request
  // byte_we and word_we are mutually exclusive levels
  typedef struct packed {
    logic                   byte_we;
    logic                   word_we;
    logic [`SPI_WORD_W-1:0] wdata;
  } host_req_t;

  // Register response
  // wait_req stalls the bus, rdata valid once it falls
  typedef struct packed {
    logic [`SPI_WORD_W-1:0] rdata;
    logic                   wait_req;
  } host_rsp_t;

  // Outgoing SD pins
  // sck on SD_SCK, mosi on SD_CMD
  typedef struct packed {
    logic sck;
    logic mosi;
  } spi_pins_t;

endpackage

//--- src/spi_sd_host.sv
// No chip select; SD_DAT[3:1] must be tied for SPI mode outside this block
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_sd_host (
  input  logic               clk,
  input  logic               resetn,
  input  spi_pkg::host_req_t i_req,
  output spi_pkg::host_rsp_t o_rsp,
  output spi_pkg::spi_pins_t o_pins,
  input  logic               i_miso
);

  // Sequencer to engine
  logic [`SPI_BYTE_W-1:0] tx_byte;
  logic                   tx_start;
  logic                   tx_ready;
  logic [`SPI_BYTE_W-1:0] rx_byte;
  logic                   rx_valid;

  // Register side, splits words into bytes
  spi_word_sequencer u_seq (
    .clk        (clk),
    .resetn     (resetn),
    .i_req      (i_req),
    .o_rsp      (o_rsp),
    .o_tx_byte  (tx_byte),
    .o_tx_start (tx_start),
    .i_tx_ready (tx_ready),
    .i_rx_byte  (rx_byte),
    .i_rx_valid (rx_valid)
  );

  // Pin side, one byte per start
  spi_byte_engine u_engine (
    .clk        (clk),
    .resetn     (resetn),
    .i_tx_byte  (tx_byte),
    .i_tx_start (tx_start),
    .o_tx_ready (tx_ready),
    .o_rx_byte  (rx_byte),
    .o_rx_valid (rx_valid),
    .o_pins     (o_pins),
    .i_miso     (i_miso)
  );

endmodule

//--- src/spi_word_sequencer.sv
// Strobe must drop in the cycle after wait falls, or the same request runs again
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_word_sequencer (
  input  logic                   clk,
  input  logic                   resetn,
  input  spi_pkg::host_req_t     i_req,
  output spi_pkg::host_rsp_t     o_rsp,
  output logic [`SPI_BYTE_W-1:0] o_tx_byte,
  output logic                   o_tx_start,
  input  logic                   i_tx_ready,
  input  logic [`SPI_BYTE_W-1:0] i_rx_byte,
  input  logic                   i_rx_valid
);

  localparam int BYTE_W     = `SPI_BYTE_W;
  localparam int WORD_BYTES = `SPI_WORD_BYTES;
  localparam int CNT_W      = (WORD_BYTES > 1) ? $clog2(WORD_BYTES) : 1;
  // Holds every byte except the last one
  localparam int BUF_W      = (WORD_BYTES - 1) * BYTE_W;

  spi_pkg::xfer_kind_e kind_q;

  logic [CNT_W-1:0]  cnt_q;
  logic [BUF_W-1:0]  rx_buf_q;
  logic [BYTE_W-1:0] tx_byte_q;
  logic              tx_start_q;
  logic              active_q;
  logic              strobe;
  logic              last_byte;
  logic              chain;
  logic              done;
  logic [CNT_W-1:0]  next_idx;

  assign strobe    = i_req.byte_we | i_req.word_we;
  // Byte kind always ends after one byte
  assign last_byte = (kind_q == spi_pkg::XFER_BYTE) || (cnt_q == '0);
  assign chain     = active_q && i_rx_valid && !last_byte;
  assign done      = active_q && i_rx_valid && last_byte;
  // Lane of the byte after the current one
  assign next_idx  = CNT_W'(WORD_BYTES - int'(cnt_q));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tx_start_q <= 1'b0;
      active_q   <= 1'b0;
      cnt_q      <= '0;
      kind_q     <= spi_pkg::XFER_BYTE;
    end else begin
      tx_start_q <= 1'b0;
      if (strobe && i_tx_ready && !active_q) begin
        // Byte 0 of a new request
        tx_start_q <= 1'b1;
        active_q   <= 1'b1;
        kind_q     <= i_req.word_we ? spi_pkg::XFER_WORD : spi_pkg::XFER_BYTE;
        // Bytes left after byte 0 of a word
        cnt_q      <= CNT_W'(WORD_BYTES - 1);
      end
      if (chain) begin
        // Next byte right after rx_valid
        tx_start_q <= 1'b1;
        cnt_q      <= cnt_q - 1'b1;
      end
      if (done) begin
        active_q <= 1'b0;
      end
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (strobe && i_tx_ready && !active_q) begin
      tx_byte_q <= i_req.wdata[BYTE_W-1:0];
      // Cleared so a byte read has zeros above [7:0]
      rx_buf_q  <= '0;
    end
    if (chain) begin
      tx_byte_q <= i_req.wdata[next_idx*BYTE_W +: BYTE_W];
      // Earlier bytes move toward the top of the word
      rx_buf_q  <= {rx_buf_q[BUF_W-BYTE_W-1:0], i_rx_byte};
    end
  end

  // Wait held until the final rx_valid
  always_comb begin
    o_rsp.wait_req = strobe && !done;
    o_rsp.rdata    = {rx_buf_q, i_rx_byte};
  end

  assign o_tx_byte  = tx_byte_q;
  assign o_tx_start = tx_start_q;

endmodule

//--- test/spi_sd_host_assertions.sv
// Bound twice; ports that a target lacks are tied to values that make those checks pass trivially
`timescale 1ns/1ps

module spi_sd_host_assertions (
  input logic clk,
  input logic resetn,
  input logic tx_start,
  input logic tx_ready,
  input logic rx_valid,
  input logic idle,
  input logic sck,
  input logic wait_req
);

  // Start only into an idle engine
  a_start_ready: assert property (@(posedge clk) disable iff (!resetn) tx_start |-> tx_ready)
    else $error("tx_start while tx_ready low");

  // Receive pulse is one cycle wide
  a_rx_pulse: assert property (@(posedge clk) disable iff (!resetn) rx_valid |=> !rx_valid)
    else $error("rx_valid held for more than one cycle");

  // SCK parked low in ST_IDLE
  a_idle_sck: assert property (@(posedge clk) disable iff (!resetn) idle |-> !sck)
    else $error("sck high while engine idle");

  // Every byte start serves a request the bus is still held on
  a_start_wait: assert property (@(posedge clk) disable iff (!resetn) tx_start |-> wait_req)
    else $error("byte started with no request waiting");

endmodule

bind spi_byte_engine spi_sd_host_assertions u_engine_sva (
  .clk      (clk),
  .resetn   (resetn),
  .tx_start (i_tx_start),
  .tx_ready (o_tx_ready),
  .rx_valid (o_rx_valid),
  .idle     (state_q == spi_pkg::ST_IDLE),
  .sck      (o_pins.sck),
  .wait_req (1'b1)
);

bind spi_word_sequencer spi_sd_host_assertions u_seq_sva (
  .clk      (clk),
  .resetn   (resetn),
  .tx_start (o_tx_start),
  .tx_ready (i_tx_ready),
  .rx_valid (i_rx_valid),
  .idle     (1'b0),
  .sck      (1'b0),
  .wait_req (o_rsp.wait_req)
);

//--- test/spi_sd_host_tb.sv
// Directed tests only; the slave model answers with bytes queued before each request
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_sd_host_tb;

  localparam int BW = `SPI_BYTE_W;
  localparam int NB = `SPI_WORD_BYTES;
  localparam int WW = `SPI_WORD_W;
  // Nominal clk cycles per byte, shifting plus start overhead
  localparam int BYTE_CYC = BW * 2 * `SPI_CLK_HALF + 6;

  logic               clk;
  logic               resetn;
  logic               miso;
  spi_pkg::host_req_t req;
  spi_pkg::host_rsp_t rsp;
  spi_pkg::spi_pins_t pins;

  // Slave model state
  logic [BW-1:0] rsp_q[$];
  logic [BW-1:0] cap_q[$];
  logic [BW-1:0] cur_byte;
  logic [BW-1:0] cap_sh;
  logic          sck_q;
  logic          loaded;
  int            bit_n;

  spi_sd_host spi_sd_host_inst (
    .clk    (clk),
    .resetn (resetn),
    .i_req  (req),
    .o_rsp  (rsp),
    .o_pins (pins),
    .i_miso (miso)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // SD card side, sampled on falling clk where SCK and MOSI are settled
  always @(negedge clk) begin
    if (pins.sck && !sck_q) begin
      // Rising SCK, MOSI in
      cap_sh = {cap_sh[BW-2:0], pins.mosi};
      bit_n++;
      if (bit_n == BW) begin
        cap_q.push_back(cap_sh);
        bit_n  = 0;
        loaded = 1'b0;
      end
    end else if (!pins.sck && sck_q && bit_n != 0) begin
      // Falling SCK, next bit out MSB first
      miso = cur_byte[BW-1-bit_n];
    end
    // First bit of the next byte set while SCK is low
    if (!loaded && !pins.sck && rsp_q.size() != 0) begin
      cur_byte = rsp_q.pop_front();
      miso     = cur_byte[BW-1];
      loaded   = 1'b1;
    end
    sck_q = pins.sck;
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input spi_pkg::host_rsp_t exp, input spi_pkg::host_rsp_t act,
                              input string name);
    if (act !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s: expected rdata %h wait %b, actual rdata %h wait %b",
                          name, exp.rdata, exp.wait_req, act.rdata, act.wait_req));
    end
  endtask

  task automatic compare_byte(input logic [BW-1:0] exp, input logic [BW-1:0] act,
                              input string name);
    if (act !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_pins(input spi_pkg::spi_pins_t exp, input spi_pkg::spi_pins_t act,
                              input string name);
    if (act !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s: expected sck,mosi %b, actual %b", name, exp, act));
    end
  endtask

  task automatic compare_flag(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Next byte the card saw on MOSI
  task automatic check_mosi(input logic [BW-1:0] exp, input string name);
    if (cap_q.size() == 0) begin
      fail_stop($sformatf("%s: the card received no byte on MOSI", name));
    end
    compare_byte(exp, cap_q.pop_front(), name);
  endtask

  // Polls wait on falling clk and counts SCK transitions meanwhile
  task automatic wait_done(input string name, input int limit,
                           output spi_pkg::host_rsp_t got, output int toggles);
    int   n;
    logic prev;
    n       = 0;
    toggles = 0;
    prev    = pins.sck;
    do begin
      @(negedge clk);
      if (pins.sck !== prev) begin
        toggles++;
      end
      prev = pins.sck;
      n++;
      if (n > limit) begin
        fail_stop($sformatf("%s: wait still high after %0d cycles", name, limit));
      end
    end while (rsp.wait_req !== 1'b0);
    got = rsp;
  endtask

  task automatic do_byte(input logic [BW-1:0] tx, input logic [BW-1:0] rx, input string name);
    spi_pkg::host_rsp_t got;
    int                 toggles;
    rsp_q.push_back(rx);
    // Upper wdata bits are junk and must not go out
    req.wdata         = WW'($urandom);
    req.wdata[BW-1:0] = tx;
    req.byte_we       = 1'b1;
    req.word_we       = 1'b0;
    wait_done(name, 2 * BYTE_CYC, got, toggles);
    req.byte_we = 1'b0;
    check_mosi(tx, name);
    compare_word('{rdata: WW'(rx), wait_req: 1'b0}, got, name);
    compare_flag(1'b1, toggles == 2 * BW, {name, " sck toggle count"});
  endtask

  // rx holds the first card byte in its top lane
  task automatic do_word(input logic [WW-1:0] tx, input logic [WW-1:0] rx, input string name);
    spi_pkg::host_rsp_t got;
    int                 toggles;
    for (int i = NB - 1; i >= 0; i--) begin
      rsp_q.push_back(rx[i*BW +: BW]);
    end
    req = '{byte_we: 1'b0, word_we: 1'b1, wdata: tx};
    wait_done(name, 2 * NB * BYTE_CYC, got, toggles);
    req.word_we = 1'b0;
    // Lowest lane goes out first
    for (int i = 0; i < NB; i++) begin
      check_mosi(tx[i*BW +: BW], name);
    end
    compare_word('{rdata: rx, wait_req: 1'b0}, got, name);
    compare_flag(1'b1, toggles == 2 * BW * NB, {name, " sck toggle count"});
  endtask

  task automatic check_reset_state();
    compare_pins('{sck: 1'b0, mosi: 1'b0}, pins, "reset pins");
    compare_flag(1'b0, rsp.wait_req, "reset wait");
  endtask

  // No idle cycle between requests
  task automatic run_mixed_stream();
    for (int i = 0; i < 8; i++) begin
      if ($urandom % 2) begin
        do_word(WW'($urandom), WW'($urandom), $sformatf("mixed %0d word", i));
      end else begin
        do_byte(BW'($urandom), BW'($urandom), $sformatf("mixed %0d byte", i));
      end
    end
  endtask

  // SCK must stay parked low once wait has fallen
  task automatic check_idle_after_word();
    do_word(WW'($urandom), WW'($urandom), "held word");
    repeat (4) begin
      @(negedge clk);
      compare_pins('{sck: 1'b0, mosi: 1'b0}, pins, "idle after word");
      compare_flag(1'b0, rsp.wait_req, "idle wait");
    end
  endtask

  task automatic run_edge_patterns();
    do_byte(8'h00, 8'h00, "pattern 00");
    do_byte(8'hFF, 8'hFF, "pattern ff");
    do_byte(8'hA5, 8'hA5, "pattern a5");
    do_word(32'h80000001, 32'h80000001, "pattern word");
  endtask

  initial begin
    void'($urandom(10077));
    resetn = 1'b0;
    req    = '0;
    miso   = 1'b0;
    sck_q  = 1'b0;
    loaded = 1'b0;
    bit_n  = 0;
    cap_sh = '0;
    repeat (8) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    check_reset_state();
    do_byte(BW'($urandom), BW'($urandom), "single byte");
    do_word(WW'($urandom), WW'($urandom), "single word");
    run_mixed_stream();
    check_idle_after_word();
    run_edge_patterns();
    $display("All tests passed");
    $finish;
  end

endmodule
